/* mac_vectors.txt */
// two runs of 12 lines, four hex words per line
// per run: A rows 0-3, B rows 0-3, then acc_out rows 0-3 summed since reset
01 02 03 04
05 06 07 08
09 0a 0b 0c
0d 0e 0f 10
01 00 02 03
00 01 01 02
02 01 00 01
01 02 03 00
000b 000d 0010 000a
001b 001d 0028 0022
002b 002d 0040 003a
003b 003d 0058 0052
ff ff ff ff
92 6d 92 6d
6d 92 ff 00
00 01 80 c3
ff 92 6d 01
ff 6d 92 00
92 ff 00 6d
6d 00 ff 92
fa0e fc0f fc12 ff0a
7fc9 1338 e90f 7d08
8f9a 7a82 81ed 6d3a
9d41 802a c327 a608

/* sources.f */
sa_pkg.sv
booth_row_encoder.sv
triple_col_precompute.sv
booth_mac_cell.sv
systolic_mac_array.sv
systolic_mac_array_assertions.sv
tb_systolic_mac_array.sv

/* tb_systolic_mac_array.sv */
`timescale 1ns/100ps

module tb_systolic_mac_array import sa_pkg::*; ();

   localparam int ROWS = 4;
   localparam int COLS = 4;
   localparam int N = 4;  // inner dimension of the matrix products
   localparam int RUNS = 2;

   localparam int RESET_CYCLES = 16;
   localparam int IDLE_CYCLES = 10;
   localparam int FEED_STEPS = N + ROWS + COLS - 2;  // skewed stream incl. trailing zeros
   localparam int SETTLE_CYCLES = ROWS + COLS + 4;
   localparam int RUN_CYCLES = FEED_STEPS + SETTLE_CYCLES;
   // two resets, two runs and the idle stretch
   localparam int TEST_CYCLES = 2 * RESET_CYCLES + 2 * RUN_CYCLES + IDLE_CYCLES;
   localparam int MAX_CYCLES = ((2 * TEST_CYCLES + 99) / 100) * 100;

   // word offsets inside one run of the vector file
   localparam int A_OFS = 0;
   localparam int B_OFS = ROWS * N;
   localparam int E_OFS = B_OFS + N * COLS;
   localparam int RUN_WORDS = E_OFS + ROWS * COLS;
   localparam int VEC_WORDS = RUNS * RUN_WORDS;

   logic                      CLK;
   logic                      arst_n;
   operand_t [ROWS-1:0]       a_in;
   operand_t [COLS-1:0]       b_in;
   acc_t [ROWS-1:0][COLS-1:0] acc_out;

   logic [15:0] vec_mem [VEC_WORDS];
   acc_t        model_acc [ROWS][COLS];  // running sum since the last reset
   int          cycle_count = 0;

   systolic_mac_array #(
      .ROWS (ROWS),
      .COLS (COLS)
   ) u_dut (
      .CLK     (CLK),
      .arst_n  (arst_n),
      .a_in    (a_in),
      .b_in    (b_in),
      .acc_out (acc_out)
   );

   initial CLK = 1'b0;
   always #5 CLK = ~CLK;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("test failed");
      $fatal(1);
   endtask

   always @(posedge CLK) begin
      cycle_count <= cycle_count + 1;
      if (u_dut.u_sva.error_count != 0) begin
         abort_run("an assertion on the DUT failed, see the error above");
      end else if (cycle_count >= MAX_CYCLES) begin
         abort_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
      end
   end

   function automatic operand_t a_elem(input int r, input int i, input int m);
      return operand_t'(vec_mem[r * RUN_WORDS + A_OFS + i * N + m]);
   endfunction

   function automatic operand_t b_elem(input int r, input int m, input int j);
      return operand_t'(vec_mem[r * RUN_WORDS + B_OFS + m * COLS + j]);
   endfunction

   function automatic acc_t file_acc(input int r, input int i, input int j);
      return acc_t'(vec_mem[r * RUN_WORDS + E_OFS + i * COLS + j]);
   endfunction

   task automatic check_value(input string name, input acc_t got, input acc_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at time %0t: %s is %h, expected %h",
                             $time, name, got, exp));
      end
   endtask

   task automatic expect_cleared();
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            check_value($sformatf("acc_out[%0d][%0d]", i, j), acc_out[i][j], acc_t'(0));
         end
      end
   endtask

   task automatic compare_with_model();
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            check_value($sformatf("acc_out[%0d][%0d]", i, j), acc_out[i][j], model_acc[i][j]);
         end
      end
   endtask

   // plain matrix product added on top, wraps mod 2^16
   task automatic accumulate_model(input int r);
      acc_t sum;
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            sum = model_acc[i][j];
            for (int m = 0; m < N; m++) begin
               sum = sum + acc_t'(a_elem(r, i, m)) * acc_t'(b_elem(r, m, j));
            end
            model_acc[i][j] = sum;
            // the file must agree with the product rule
            check_value($sformatf("expected acc[%0d][%0d] of run %0d in mac_vectors.txt",
                                  i, j, r), file_acc(r, i, j), sum);
         end
      end
   endtask

   // row i delayed by i steps, column j by j steps
   task automatic feed_run(input int r);
      int ia;
      int jb;
      for (int t = 0; t < FEED_STEPS; t++) begin
         for (int i = 0; i < ROWS; i++) begin
            ia = t - i;
            a_in[i] = (ia >= 0 && ia < N) ? a_elem(r, i, ia) : '0;
         end
         for (int j = 0; j < COLS; j++) begin
            jb = t - j;
            b_in[j] = (jb >= 0 && jb < N) ? b_elem(r, jb, j) : '0;
         end
         @(negedge CLK);
      end
      a_in = '0;
      b_in = '0;
      repeat (SETTLE_CYCLES) @(negedge CLK);
   endtask

   initial begin
      arst_n = 1'b0;
      a_in = '0;
      b_in = '0;
      for (int i = 0; i < ROWS; i++) begin
         for (int j = 0; j < COLS; j++) begin
            model_acc[i][j] = '0;
         end
      end
      $readmemh("mac_vectors.txt", vec_mem);
      if ($isunknown(vec_mem[0]) || $isunknown(vec_mem[VEC_WORDS-1])) begin
         abort_run("mac_vectors.txt could not be read or holds too few words");
      end

      repeat (RESET_CYCLES) @(negedge CLK);
      expect_cleared();
      arst_n = 1'b1;
      @(negedge CLK);
      expect_cleared();  // encoders still output zero codes

      feed_run(0);
      accumulate_model(0);
      compare_with_model();

      // no reset, accumulators carry over
      feed_run(1);
      accumulate_model(1);
      compare_with_model();

      repeat (IDLE_CYCLES) begin
         @(negedge CLK);
         compare_with_model();
      end

      arst_n = 1'b0;
      #1;
      expect_cleared();
      @(negedge CLK);
      expect_cleared();

      if (u_dut.u_sva.error_count != 0) begin
         abort_run($sformatf("%0d assertion failures were reported",
                             u_dut.u_sva.error_count));
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

/* systolic_mac_array_assertions.sv */
`timescale 1ns/100ps

module systolic_mac_array_assertions import sa_pkg::*; #(
   parameter int ROWS = 4,
   parameter int COLS = 4
) (
   input logic                      CLK,
   input logic                      arst_n,
   input operand_t [ROWS-1:0]       a_in,
   input operand_t [COLS-1:0]       b_in,
   input acc_t [ROWS-1:0][COLS-1:0] acc_out
);

   int error_count = 0;  // read by the testbench

   // async clear, so the sample one edge later is still zero
   a_acc_cleared: assert property (@(posedge CLK) !arst_n |=> acc_out == '0)
      else begin
         error_count++;
         $error("acc_out not zero while arst_n is low");
      end

   a_acc_known: assert property (@(posedge CLK) disable iff (!arst_n) !$isunknown(acc_out))
      else begin
         error_count++;
         $error("acc_out has unknown bits after reset");
      end

   a_inputs_known: assert property (@(posedge CLK) disable iff (!arst_n)
                                    !$isunknown({a_in, b_in}))
      else begin
         error_count++;
         $error("a_in or b_in has unknown bits after reset");
      end

endmodule

bind systolic_mac_array systolic_mac_array_assertions #(
   .ROWS (ROWS),
   .COLS (COLS)
) u_sva (.*);

/* systolic_mac_array.sv */
`timescale 1ns/100ps

module systolic_mac_array import sa_pkg::*; #(
   parameter int ROWS = 4,
   parameter int COLS = 4
) (
   input  logic                        CLK,
   input  logic                        arst_n,
   input  operand_t [ROWS-1:0]         a_in,    // one row operand per row
   input  operand_t [COLS-1:0]         b_in,    // one column operand per column
   output acc_t [ROWS-1:0][COLS-1:0]   acc_out
);

   // inputs seen by cell (i,j)
   booth_code_t code_w [ROWS][COLS];
   operand_t    op_w   [ROWS][COLS];
   triple_t     tri_w  [ROWS][COLS];

   // left edge, one encoder per row
   for (genvar i = 0; i < ROWS; i++) begin : g_enc
      booth_row_encoder u_enc (
         .CLK     (CLK),
         .arst_n  (arst_n),
         .operand (a_in[i]),
         .code    (code_w[i][0])
      );
   end

   // top edge, one triple precompute per column
   for (genvar j = 0; j < COLS; j++) begin : g_pre
      triple_col_precompute u_pre (
         .CLK       (CLK),
         .arst_n    (arst_n),
         .operand   (b_in[j]),
         .operand_q (op_w[0][j]),
         .triple_q  (tri_w[0][j])
      );
   end

   for (genvar i = 0; i < ROWS; i++) begin : g_row
      for (genvar j = 0; j < COLS; j++) begin : g_col
         if (i < ROWS - 1 && j < COLS - 1) begin : g_inner
            booth_mac_cell u_cell (
               .CLK         (CLK),
               .arst_n      (arst_n),
               .code_in     (code_w[i][j]),
               .operand_in  (op_w[i][j]),
               .triple_in   (tri_w[i][j]),
               .code_out    (code_w[i][j+1]),
               .operand_out (op_w[i+1][j]),
               .triple_out  (tri_w[i+1][j]),
               .acc         (acc_out[i][j])
            );
         end else if (j < COLS - 1) begin : g_bottom
            // last row, code still moves right
            booth_mac_cell u_cell (
               .CLK         (CLK),
               .arst_n      (arst_n),
               .code_in     (code_w[i][j]),
               .operand_in  (op_w[i][j]),
               .triple_in   (tri_w[i][j]),
               .code_out    (code_w[i][j+1]),
               .operand_out (),
               .triple_out  (),
               .acc         (acc_out[i][j])
            );
         end else if (i < ROWS - 1) begin : g_right
            // last column, operands still move down
            booth_mac_cell u_cell (
               .CLK         (CLK),
               .arst_n      (arst_n),
               .code_in     (code_w[i][j]),
               .operand_in  (op_w[i][j]),
               .triple_in   (tri_w[i][j]),
               .code_out    (),
               .operand_out (op_w[i+1][j]),
               .triple_out  (tri_w[i+1][j]),
               .acc         (acc_out[i][j])
            );
         end else begin : g_corner
            booth_mac_cell u_cell (
               .CLK         (CLK),
               .arst_n      (arst_n),
               .code_in     (code_w[i][j]),
               .operand_in  (op_w[i][j]),
               .triple_in   (tri_w[i][j]),
               .code_out    (),
               .operand_out (),
               .triple_out  (),
               .acc         (acc_out[i][j])
            );
         end
      end
   end

endmodule

/* booth_mac_cell.sv */
`timescale 1ns/100ps

module booth_mac_cell import sa_pkg::*; (
   input  logic        CLK,
   input  logic        arst_n,
   input  booth_code_t code_in,     // from the left neighbour or the row encoder
   input  operand_t    operand_in,  // from the cell above or the column precompute
   input  triple_t     triple_in,
   output booth_code_t code_out,
   output operand_t    operand_out,
   output triple_t     triple_out,
   output acc_t        acc
);

   acc_t pp [GROUPS];  // weighted partial products
   acc_t product;

   // picks y, 2y, 3y or 4y for one digit, then applies the sign
   function automatic acc_t select_pp(
      input booth_digit_t dig,
      input operand_t     y,
      input triple_t      ty
   );
      acc_t mag;
      acc_t inv;
      mag = ({ACC_W{dig.single}} & acc_t'(y))
          | ({ACC_W{dig.double}} & (acc_t'(y) << 1))
          | ({ACC_W{dig.triple}} & acc_t'(ty))
          | ({ACC_W{dig.quad}} & (acc_t'(y) << 2));
      inv = mag ^ {ACC_W{dig.neg}};
      // negative zero magnitude wraps back to 0
      return inv + acc_t'(dig.neg);
   endfunction

   // partial sums may dip below zero
   // the full product of two 8-bit operands still fits in 16 bits
   always_comb begin
      product = '0;
      for (int g = 0; g < GROUPS; g++) begin
         pp[g] = select_pp(code_in[g], operand_in, triple_in) << (GROUP_SHIFT * g);
         product = product + pp[g];
      end
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         acc <= '0;
      end else begin
         acc <= acc + product;  // wraps mod 2^16
      end
   end

   // forwarding stage, same edge as the accumulate
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         code_out <= '0;
         operand_out <= '0;
         triple_out <= '0;
      end else begin
         code_out <= code_in;        // moves right
         operand_out <= operand_in;  // moves down
         triple_out <= triple_in;
      end
   end

endmodule

/* triple_col_precompute.sv */
`timescale 1ns/100ps

module triple_col_precompute import sa_pkg::*; (
   input  logic     CLK,
   input  logic     arst_n,
   input  operand_t operand,
   output operand_t operand_q,
   output triple_t  triple_q
);

   triple_t triple_d;

   // one adder per column, shared by every cell below
   assign triple_d = triple_t'(operand) + (triple_t'(operand) << 1);

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         operand_q <= '0;
         triple_q <= '0;
      end else begin
         operand_q <= operand;
         triple_q <= triple_d;  // stays aligned with operand_q
      end
   end

endmodule

/* booth_row_encoder.sv */
`timescale 1ns/100ps

module booth_row_encoder import sa_pkg::*; (
   input  logic        CLK,
   input  logic        arst_n,
   input  operand_t    operand,
   output booth_code_t code
);

   logic [3:0] win [GROUPS];  // overlapping 4-bit windows, msb is the sign bit
   booth_code_t code_d;

   // window {x3,x2,x1,x0} stands for -4*x3 + 2*x2 + x1 + x0
   function automatic booth_digit_t decode_digit(input logic [3:0] x);
      logic w0;
      logic w1;
      logic w2;
      booth_digit_t d;
      w0 = x[0] ^ x[1];
      w1 = x[1] ^ x[2];
      w2 = x[2] ^ x[3];
      d.single = w0 & ~w2;        // |digit| = 1
      d.double = w1 & ~w0;        // |digit| = 2
      d.triple = w2 & w0;         // |digit| = 3
      d.quad = w2 & ~(w0 | w1);   // |digit| = 4
      d.neg = x[3];
      return d;
   endfunction

   assign win[0] = {operand[2:0], 1'b0};
   assign win[1] = operand[5:2];
   assign win[2] = {1'b0, operand[OPERAND_W-1 -: 3]};  // top group never negative

   always_comb begin
      for (int g = 0; g < GROUPS; g++) begin
         code_d[g] = decode_digit(win[g]);
      end
   end

   // one cycle of latency, code valid after the sampling edge
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         code <= '0;
      end else begin
         code <= code_d;
      end
   end

endmodule

/* sa_pkg.sv */
package sa_pkg;

   // operand width is fixed, the three-group radix-8 split depends on it
   localparam int OPERAND_W = 8;
   localparam int GROUPS = 3;

   localparam int TRIPLE_W = OPERAND_W + 2;  // 3*255 needs 10 bits
   localparam int ACC_W = 2 * OPERAND_W;

   // bit distance between adjacent radix-8 groups
   localparam int GROUP_SHIFT = 3;

   typedef logic [OPERAND_W-1:0] operand_t;  // unsigned row or column operand
   typedef logic [TRIPLE_W-1:0] triple_t;    // three times a column operand
   typedef logic [ACC_W-1:0] acc_t;          // product and accumulator, mod 2^16

   // one radix-8 digit
   // at most one magnitude bit is set, none set means zero
   typedef struct packed {
      logic single;
      logic double;
      logic triple;
      logic quad;
      logic neg;
   } booth_digit_t;

   // group 0 sits in the low bits
   typedef booth_digit_t [GROUPS-1:0] booth_code_t;

endpackage
